//--- Bender.yml
package:
  name: dpCore

sources:
  - include_dirs:
      - common
    files:
      - common/dpPkg.sv
      - src/pipeReg.sv
      - src/regFile.sv
      - decode/decodeStage.sv
      - execute/executeStage.sv
      - src/hazardUnit.sv
      - src/dpCore.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/tbDpCore.sv

//--- common/dpPkg.sv
`include "dp_config.svh"

package dpPkg;

    // ALU operations used by the supported instructions
    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt
    } aluOpT;

    // Fetch to decode
    typedef struct packed {
        logic                   valid;
        logic [`DP_XLEN-1:0]    instr;
        logic [`DP_XLEN-1:0]    pc;
    } fetchT;

    // Decode to execute
    typedef struct packed {
        logic                   valid;
        logic [`DP_REGADDR-1:0] rs1;
        logic [`DP_REGADDR-1:0] rs2;
        logic [`DP_REGADDR-1:0] rd;
        logic [`DP_XLEN-1:0]    rd1;
        logic [`DP_XLEN-1:0]    rd2;
        logic [`DP_XLEN-1:0]    pc;
        logic [`DP_XLEN-1:0]    imm;
        aluOpT                  aluOp;
        logic                   useImm;
        logic                   regWrite;
        logic                   memRead;
        logic                   memWrite;
        logic                   branch;
    } decodeT;

    // Execute to writeback, rd of zero means nothing is written
    typedef struct packed {
        logic                   valid;
        logic [`DP_REGADDR-1:0] rd;
        logic [`DP_XLEN-1:0]    data;
    } wbT;

endpackage

//--- common/dp_config.svh
`ifndef DP_CONFIG_SVH
`define DP_CONFIG_SVH

// Data and address width
`define DP_XLEN 32

// Register file has 32 entries
`define DP_REGADDR 5

`endif

//--- decode/decodeStage.sv
`timescale 1ns/1ps
`include "dp_config.svh"

module decodeStage import dpPkg::*; (
    input  logic   clk,
    input  logic   arstN,
    input  fetchT  fetchD,
    input  wbT     wbW,
    output decodeT decodeD
);

    localparam logic [6:0] OpRType  = 7'b0110011;
    localparam logic [6:0] OpImm    = 7'b0010011;
    localparam logic [6:0] OpLoad   = 7'b0000011;
    localparam logic [6:0] OpStore  = 7'b0100011;
    localparam logic [6:0] OpBranch = 7'b1100011;

    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic [`DP_REGADDR-1:0] rdField;
    logic [`DP_REGADDR-1:0] rs1Field;
    logic [`DP_REGADDR-1:0] rs2Field;
    logic [`DP_XLEN-1:0]    immI;
    logic [`DP_XLEN-1:0]    immS;
    logic [`DP_XLEN-1:0]    immB;
    logic [`DP_XLEN-1:0]    imm;
    logic [`DP_XLEN-1:0]    rd1;
    logic [`DP_XLEN-1:0]    rd2;
    aluOpT                  aluOp;
    logic                   useRs1;
    logic                   useRs2;
    logic                   useImm;
    logic                   regWrite;
    logic                   memRead;
    logic                   memWrite;
    logic                   branch;

    assign opcode   = fetchD.instr[6:0];
    assign rdField  = fetchD.instr[11:7];
    assign funct3   = fetchD.instr[14:12];
    assign rs1Field = fetchD.instr[19:15];
    assign rs2Field = fetchD.instr[24:20];
    assign funct7   = fetchD.instr[31:25];

    // Sign-extended immediates
    assign immI = {{20{fetchD.instr[31]}}, fetchD.instr[31:20]};
    assign immS = {{20{fetchD.instr[31]}}, fetchD.instr[31:25], fetchD.instr[11:7]};
    assign immB = {{19{fetchD.instr[31]}}, fetchD.instr[31], fetchD.instr[7],
                   fetchD.instr[30:25], fetchD.instr[11:8], 1'b0};

    // Anything not matched below stays a no-op
    always_comb begin
        aluOp    = aluAdd;
        imm      = '0;
        useRs1   = 1'b0;
        useRs2   = 1'b0;
        useImm   = 1'b0;
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        branch   = 1'b0;
        case (opcode)
            OpRType: begin
                regWrite = 1'b1;
                useRs1   = 1'b1;
                useRs2   = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: aluOp = aluAdd;
                    10'b0100000_000: aluOp = aluSub;
                    10'b0000000_111: aluOp = aluAnd;
                    10'b0000000_110: aluOp = aluOr;
                    10'b0000000_100: aluOp = aluXor;
                    10'b0000000_010: aluOp = aluSlt;
                    default: begin
                        regWrite = 1'b0;
                        useRs1   = 1'b0;
                        useRs2   = 1'b0;
                    end
                endcase
            end
            OpImm: begin
                if (funct3 == 3'b000) begin
                    useRs1   = 1'b1;
                    useImm   = 1'b1;
                    regWrite = 1'b1;
                    imm      = immI;
                end
            end
            OpLoad: begin
                if (funct3 == 3'b010) begin
                    useRs1   = 1'b1;
                    useImm   = 1'b1;
                    regWrite = 1'b1;
                    memRead  = 1'b1;
                    imm      = immI;
                end
            end
            OpStore: begin
                if (funct3 == 3'b010) begin
                    useRs1   = 1'b1;
                    useRs2   = 1'b1;
                    useImm   = 1'b1;
                    memWrite = 1'b1;
                    imm      = immS;
                end
            end
            OpBranch: begin
                // BEQ only, compare happens in execute
                if (funct3 == 3'b000) begin
                    useRs1 = 1'b1;
                    useRs2 = 1'b1;
                    branch = 1'b1;
                    imm    = immB;
                end
            end
            default: ;
        endcase
    end

    regFile i_regFile (
        .clk   (clk),
        .arstN (arstN),
        .ra1   (rs1Field),
        .ra2   (rs2Field),
        .we    (wbW.valid),
        .wa    (wbW.rd),
        .wd    (wbW.data),
        .rd1   (rd1),
        .rd2   (rd2)
    );

    // Unused source fields read as x0 so the hazard unit ignores them
    always_comb begin
        decodeD.valid    = fetchD.valid;
        decodeD.rs1      = (fetchD.valid && useRs1) ? rs1Field : '0;
        decodeD.rs2      = (fetchD.valid && useRs2) ? rs2Field : '0;
        decodeD.rd       = (fetchD.valid && regWrite) ? rdField : '0;
        decodeD.rd1      = rd1;
        decodeD.rd2      = rd2;
        decodeD.pc       = fetchD.pc;
        decodeD.imm      = imm;
        decodeD.aluOp    = aluOp;
        decodeD.useImm   = useImm;
        decodeD.regWrite = fetchD.valid && regWrite;
        decodeD.memRead  = fetchD.valid && memRead;
        decodeD.memWrite = fetchD.valid && memWrite;
        decodeD.branch   = fetchD.valid && branch;
    end

endmodule

//--- execute/executeStage.sv
`timescale 1ns/1ps
`include "dp_config.svh"

module executeStage import dpPkg::*; (
    input  decodeT              decodeE,
    input  logic [`DP_XLEN-1:0] memRdata,
    output wbT                  wbE,
    output logic                redirect,
    output logic [`DP_XLEN-1:0] redirectPc,
    output logic                memReq,
    output logic                memWe,
    output logic [`DP_XLEN-1:0] memAddr,
    output logic [`DP_XLEN-1:0] memWdata
);

    logic [`DP_XLEN-1:0] srcB;
    logic [`DP_XLEN-1:0] aluResult;

    assign srcB = decodeE.useImm ? decodeE.imm : decodeE.rd2;

    always_comb begin
        case (decodeE.aluOp)
            aluAdd:  aluResult = decodeE.rd1 + srcB;
            aluSub:  aluResult = decodeE.rd1 - srcB;
            aluAnd:  aluResult = decodeE.rd1 & srcB;
            aluOr:   aluResult = decodeE.rd1 | srcB;
            aluXor:  aluResult = decodeE.rd1 ^ srcB;
            aluSlt:  aluResult = {31'd0, $signed(decodeE.rd1) < $signed(srcB)};
            default: aluResult = '0;
        endcase
    end

    // BEQ resolves here with a target relative to the branch itself
    assign redirect   = decodeE.valid && decodeE.branch && (decodeE.rd1 == decodeE.rd2);
    assign redirectPc = decodeE.pc + decodeE.imm;

    // Address comes from the adder and store data from rs2
    assign memReq   = decodeE.valid && (decodeE.memRead || decodeE.memWrite);
    assign memWe    = decodeE.valid && decodeE.memWrite;
    assign memAddr  = aluResult;
    assign memWdata = decodeE.rd2;

    // Stores, branches and no-ops retire with rd of x0
    always_comb begin
        wbE.valid = decodeE.valid;
        wbE.rd    = decodeE.regWrite ? decodeE.rd : '0;
        wbE.data  = decodeE.memRead ? memRdata : aluResult;
    end

    // Hazard priority assumes a branch never meets a memory access in execute
    always_comb begin
        branchNotMem: assert final (!(redirect && memReq))
            else $error("executeStage: branch and memory request together");
    end

endmodule

//--- sim.f
+incdir+common
common/dpPkg.sv
src/pipeReg.sv
src/regFile.sv
decode/decodeStage.sv
execute/executeStage.sv
src/hazardUnit.sv
src/dpCore.sv
tests/tbDpCore.sv

//--- src/dpCore.sv
`timescale 1ns/1ps
`include "dp_config.svh"

module dpCore import dpPkg::*; (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic [`DP_XLEN-1:0]    instr,
    input  logic [`DP_XLEN-1:0]    pc,
    input  logic                   instrValid,
    output logic                   stallF,
    output logic                   redirect,
    output logic [`DP_XLEN-1:0]    redirectPc,
    output logic                   memReq,
    output logic                   memWe,
    output logic [`DP_XLEN-1:0]    memAddr,
    output logic [`DP_XLEN-1:0]    memWdata,
    input  logic [`DP_XLEN-1:0]    memRdata,
    input  logic                   memReady,
    output logic                   wbValid,
    output logic [`DP_REGADDR-1:0] wbRd,
    output logic [`DP_XLEN-1:0]    wbData
);

    fetchT  fetchF;
    fetchT  fetchD;
    decodeT decodeD;
    decodeT decodeE;
    wbT     wbE;
    wbT     wbW;
    logic   stallD;
    logic   stallE;
    logic   flushD;
    logic   flushE;
    logic   flushW;

    assign fetchF = '{valid: instrValid, instr: instr, pc: pc};

    pipeReg #(.T(fetchT)) i_regFD (
        .clk   (clk),
        .arstN (arstN),
        .stall (stallD),
        .flush (flushD),
        .d     (fetchF),
        .q     (fetchD)
    );

    decodeStage i_decode (
        .clk     (clk),
        .arstN   (arstN),
        .fetchD  (fetchD),
        .wbW     (wbW),
        .decodeD (decodeD)
    );

    pipeReg #(.T(decodeT)) i_regDE (
        .clk   (clk),
        .arstN (arstN),
        .stall (stallE),
        .flush (flushE),
        .d     (decodeD),
        .q     (decodeE)
    );

    executeStage i_execute (
        .decodeE    (decodeE),
        .memRdata   (memRdata),
        .wbE        (wbE),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .memReq     (memReq),
        .memWe      (memWe),
        .memAddr    (memAddr),
        .memWdata   (memWdata)
    );

    // Writeback never stalls, a memory wait only inserts bubbles
    pipeReg #(.T(wbT)) i_regEW (
        .clk   (clk),
        .arstN (arstN),
        .stall (1'b0),
        .flush (flushW),
        .d     (wbE),
        .q     (wbW)
    );

    hazardUnit i_hazard (
        .rs1D      (decodeD.rs1),
        .rs2D      (decodeD.rs2),
        .validD    (decodeD.valid),
        .rdE       (decodeE.rd),
        .regWriteE (decodeE.regWrite),
        .validE    (decodeE.valid),
        .memReq    (memReq),
        .memReady  (memReady),
        .redirect  (redirect),
        .stallF    (stallF),
        .stallD    (stallD),
        .stallE    (stallE),
        .flushD    (flushD),
        .flushE    (flushE),
        .flushW    (flushW)
    );

    assign wbValid = wbW.valid;
    assign wbRd    = wbW.rd;
    assign wbData  = wbW.data;

endmodule

//--- src/hazardUnit.sv
`timescale 1ns/1ps
`include "dp_config.svh"

module hazardUnit (
    input  logic [`DP_REGADDR-1:0] rs1D,
    input  logic [`DP_REGADDR-1:0] rs2D,
    input  logic                   validD,
    input  logic [`DP_REGADDR-1:0] rdE,
    input  logic                   regWriteE,
    input  logic                   validE,
    input  logic                   memReq,
    input  logic                   memReady,
    input  logic                   redirect,
    output logic                   stallF,
    output logic                   stallD,
    output logic                   stallE,
    output logic                   flushD,
    output logic                   flushE,
    output logic                   flushW
);

    logic memWait;
    logic rawHazard;

    assign memWait = memReq && !memReady;

    // Without forwarding decode waits for the writer in execute to reach writeback
    assign rawHazard = validD && validE && regWriteE && (rdE != '0)
                       && ((rdE == rs1D) || (rdE == rs2D));

    // Memory wait freezes everything up to execute
    assign stallF = memWait || (rawHazard && !redirect);
    assign stallD = stallF;
    assign stallE = memWait;
    assign flushW = memWait;

    // Taken branch kills the two younger instructions
    assign flushD = redirect && !memWait;
    assign flushE = !memWait && (redirect || rawHazard);

    // A stage is never held and flushed in the same cycle
    always_comb begin
        holdOrFlush: assert final (!(stallD && flushD) && !(stallE && flushE))
            else $error("hazardUnit: stage stalled and flushed together");
    end

endmodule

//--- src/pipeReg.sv
`timescale 1ns/1ps

module pipeReg import dpPkg::*; #(
    parameter type T = fetchT
) (
    input  logic clk,
    input  logic arstN,
    input  logic stall,
    input  logic flush,
    input  T     d,
    output T     q
);

    // Flush wins over stall and leaves an invalid payload
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

    // Held stage keeps its payload through the stalled edge
    holdOnStall: assert property (
        @(posedge clk) disable iff (!arstN)
        (stall && !flush) |=> $stable(q)
    ) else $error("pipeReg: payload changed while stalled");

endmodule

//--- src/regFile.sv
`timescale 1ns/1ps
`include "dp_config.svh"

module regFile (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic [`DP_REGADDR-1:0] ra1,
    input  logic [`DP_REGADDR-1:0] ra2,
    input  logic                   we,
    input  logic [`DP_REGADDR-1:0] wa,
    input  logic [`DP_XLEN-1:0]    wd,
    output logic [`DP_XLEN-1:0]    rd1,
    output logic [`DP_XLEN-1:0]    rd2
);

    logic [`DP_XLEN-1:0] regs [32];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // Write-first bypass lets decode see a retiring result in the same cycle
    assign rd1 = (ra1 == '0) ? '0 : ((we && wa == ra1) ? wd : regs[ra1]);
    assign rd2 = (ra2 == '0) ? '0 : ((we && wa == ra2) ? wd : regs[ra2]);

    // A register written at one edge reads back the written value in the next cycle
    readBack: assert property (
        @(posedge clk) disable iff (!arstN)
        ($past(we) && $past(wa) == ra1 && ra1 != '0 && !(we && wa == ra1))
            |-> (rd1 == $past(wd))
    ) else $error("regFile: written value not read back");

endmodule

//--- tests/tbDpCore.sv
`timescale 1ns/1ps
`include "dp_config.svh"

module tbDpCore import dpPkg::*; ();

    localparam int ClkPeriod = 100;
    // Instruction count over all programs sets the watchdog limit
    localparam int TotalInstr = 42;
    localparam int WatchdogCycles = TotalInstr * 20 + 200;

    logic                   clk = 1'b0;
    logic                   arstN;
    logic [`DP_XLEN-1:0]    instr;
    logic [`DP_XLEN-1:0]    fetchPc;
    logic                   instrValid;
    logic                   stallF;
    logic                   redirect;
    logic [`DP_XLEN-1:0]    redirectPc;
    logic                   memReq;
    logic                   memWe;
    logic [`DP_XLEN-1:0]    memAddr;
    logic [`DP_XLEN-1:0]    memWdata;
    logic [`DP_XLEN-1:0]    memRdata;
    logic                   memReady;
    logic                   wbValid;
    logic [`DP_REGADDR-1:0] wbRd;
    logic [`DP_XLEN-1:0]    wbData;

    logic [`DP_XLEN-1:0] prog [$];
    logic [`DP_XLEN-1:0] dmem [256];
    logic [`DP_XLEN-1:0] modelRegs [32];
    logic [`DP_XLEN-1:0] modelMem [256];
    wbT                  expected [$];
    wbT                  retired [$];
    int                  retireCycle [$];
    logic [15:0]         lfsr = 16'd31439;
    int                  cycle = 0;
    int                  firstAccept = -1;
    logic                sawStall = 1'b0;
    logic                prevWait = 1'b0;
    logic                drvHold;
    logic                drvJump;
    logic                drvReset;
    logic [`DP_XLEN-1:0] drvTarget;

    dpCore i_dut (
        .clk        (clk),
        .arstN      (arstN),
        .instr      (instr),
        .pc         (fetchPc),
        .instrValid (instrValid),
        .stallF     (stallF),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .memReq     (memReq),
        .memWe      (memWe),
        .memAddr    (memAddr),
        .memWdata   (memWdata),
        .memRdata   (memRdata),
        .memReady   (memReady),
        .wbValid    (wbValid),
        .wbRd       (wbRd),
        .wbData     (wbData)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    always @(posedge clk) cycle++;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [`DP_XLEN-1:0] fillWord(input int idx);
        logic [`DP_XLEN-1:0] addr;
        addr = idx << 2;
        return {~addr[15:0], addr[15:0]};
    endfunction

    // RV32I encodings
    function automatic logic [31:0] rOp(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lw(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sw(input logic [4:0] rs2, rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] beq(input logic [4:0] rs1, rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    task automatic stopRun();
        $display("test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic failNow(input string msg);
        $display("Error: %s", msg);
        stopRun();
    endtask

    task automatic compareWb(input string name, input wbT exp, input wbT act);
        if (exp.valid !== act.valid || exp.rd !== act.rd
            || (exp.rd != '0 && exp.data !== act.data)) begin
            $display("Mismatch in %s: expected rd %0d data %h, actual rd %0d data %h",
                     name, exp.rd, exp.data, act.rd, act.data);
            stopRun();
        end
    endtask

    task automatic checkWord(input string name, input logic [`DP_XLEN-1:0] exp,
                             input logic [`DP_XLEN-1:0] act);
        if (exp !== act) begin
            $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
            stopRun();
        end
    endtask

    task automatic expectBit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Mismatch in %s: expected %b, actual %b", name, exp, act);
            stopRun();
        end
    endtask

    task automatic controlsIdle(input string name);
        expectBit({name, " stallF"}, 1'b0, stallF);
        expectBit({name, " redirect"}, 1'b0, redirect);
        expectBit({name, " memReq"}, 1'b0, memReq);
        expectBit({name, " wbValid"}, 1'b0, wbValid);
    endtask

    // Controls stay idle through two reset cycles and right after release
    task automatic applyReset(input string name);
        @(posedge clk);
        #1;
        arstN = 1'b0;
        for (int i = 0; i < 256; i++) begin
            dmem[i] = fillWord(i);
        end
        retired.delete();
        retireCycle.delete();
        sawStall = 1'b0;
        repeat (2) begin
            @(negedge clk);
            controlsIdle(name);
            @(posedge clk);
        end
        #1;
        arstN = 1'b1;
        @(negedge clk);
        controlsIdle(name);
    endtask

    // Architectural run of prog with one expected retirement per executed instruction
    task automatic runModel();
        logic [`DP_XLEN-1:0] ins;
        logic [`DP_XLEN-1:0] a;
        logic [`DP_XLEN-1:0] b;
        logic [`DP_XLEN-1:0] immI;
        logic [`DP_XLEN-1:0] immS;
        logic [`DP_XLEN-1:0] immB;
        logic [`DP_XLEN-1:0] res;
        logic [`DP_XLEN-1:0] addr;
        logic [`DP_XLEN-1:0] mpc;
        logic [`DP_XLEN-1:0] nextPc;
        logic                writes;
        int                  steps;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            modelMem[i] = fillWord(i);
        end
        expected.delete();
        mpc = '0;
        steps = 0;
        while ((mpc >> 2) < prog.size() && steps < 200) begin
            ins    = prog[mpc >> 2];
            a      = modelRegs[ins[19:15]];
            b      = modelRegs[ins[24:20]];
            immI   = {{20{ins[31]}}, ins[31:20]};
            immS   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            immB   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            res    = '0;
            writes = 1'b0;
            nextPc = mpc + 4;
            case (ins[6:0])
                7'b0110011: begin
                    writes = 1'b1;
                    case ({ins[31:25], ins[14:12]})
                        10'b0000000_000: res = a + b;
                        10'b0100000_000: res = a - b;
                        10'b0000000_111: res = a & b;
                        10'b0000000_110: res = a | b;
                        10'b0000000_100: res = a ^ b;
                        10'b0000000_010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: writes = 1'b0;
                    endcase
                end
                7'b0010011: begin
                    writes = (ins[14:12] == 3'b000);
                    res    = a + immI;
                end
                7'b0000011: begin
                    writes = (ins[14:12] == 3'b010);
                    addr   = a + immI;
                    res    = modelMem[addr[9:2]];
                end
                7'b0100011: begin
                    addr = a + immS;
                    if (ins[14:12] == 3'b010) begin
                        modelMem[addr[9:2]] = b;
                    end
                end
                7'b1100011: begin
                    if (ins[14:12] == 3'b000 && a == b) begin
                        nextPc = mpc + immB;
                    end
                end
                default: ;
            endcase
            if (writes && ins[11:7] != '0) begin
                modelRegs[ins[11:7]] = res;
            end
            expected.push_back('{valid: 1'b1, rd: writes ? ins[11:7] : 5'd0, data: res});
            mpc = nextPc;
            steps++;
        end
    endtask

    task automatic runProgram(input string name);
        int waited;
        runModel();
        applyReset(name);
        waited = 0;
        while (retired.size() < expected.size() && waited < prog.size() * 20) begin
            @(posedge clk);
            waited++;
        end
        if (retired.size() < expected.size()) begin
            failNow($sformatf("%s: only %0d of %0d instructions retired",
                              name, retired.size(), expected.size()));
        end else begin
            for (int i = 0; i < expected.size(); i++) begin
                compareWb(name, expected[i], retired[i]);
            end
        end
    endtask

    task automatic resetState();
        prog.delete();
        applyReset("resetState");
    endtask

    task automatic aluSequence();
        prog.delete();
        prog.push_back(addi(5'd1, 5'd0, 12'd25));
        prog.push_back(addi(5'd2, 5'd0, -12'd7));
        prog.push_back(addi(5'd3, 5'd0, 12'd100));
        prog.push_back(rOp(7'h00, 3'd0, 5'd4, 5'd1, 5'd2));
        prog.push_back(rOp(7'h20, 3'd0, 5'd5, 5'd1, 5'd3));
        prog.push_back(rOp(7'h00, 3'd7, 5'd6, 5'd2, 5'd3));
        prog.push_back(rOp(7'h00, 3'd6, 5'd7, 5'd1, 5'd2));
        prog.push_back(rOp(7'h00, 3'd4, 5'd8, 5'd3, 5'd2));
        prog.push_back(rOp(7'h00, 3'd2, 5'd9, 5'd2, 5'd1));
        prog.push_back(rOp(7'h00, 3'd2, 5'd10, 5'd1, 5'd2));
        runProgram("aluSequence");
        checkWord("aluSequence latency", 32'd3, retireCycle[0] - firstAccept);
        for (int i = 1; i < retireCycle.size(); i++) begin
            checkWord("aluSequence spacing", retireCycle[0] + i, retireCycle[i]);
        end
    endtask

    task automatic rawChains();
        prog.delete();
        prog.push_back(addi(5'd1, 5'd0, 12'd5));
        prog.push_back(addi(5'd1, 5'd1, 12'd3));
        prog.push_back(rOp(7'h00, 3'd0, 5'd2, 5'd1, 5'd1));
        prog.push_back(rOp(7'h20, 3'd0, 5'd3, 5'd2, 5'd1));
        // Write to x0 must not stick
        prog.push_back(addi(5'd0, 5'd3, 12'd77));
        prog.push_back(rOp(7'h00, 3'd0, 5'd4, 5'd0, 5'd3));
        prog.push_back(rOp(7'h00, 3'd4, 5'd5, 5'd4, 5'd0));
        prog.push_back(addi(5'd6, 5'd5, -12'd1));
        runProgram("rawChains");
        expectBit("rawChains stall seen", 1'b1, sawStall);
    endtask

    task automatic loadStore();
        prog.delete();
        prog.push_back(addi(5'd1, 5'd0, 12'd64));
        prog.push_back(addi(5'd2, 5'd0, 12'd1234));
        prog.push_back(sw(5'd2, 5'd1, 12'd0));
        prog.push_back(addi(5'd3, 5'd0, -12'd55));
        prog.push_back(sw(5'd3, 5'd1, 12'd8));
        prog.push_back(lw(5'd4, 5'd1, 12'd0));
        prog.push_back(lw(5'd5, 5'd1, 12'd8));
        prog.push_back(rOp(7'h00, 3'd0, 5'd6, 5'd4, 5'd5));
        prog.push_back(lw(5'd7, 5'd1, 12'd4));
        prog.push_back(sw(5'd6, 5'd1, 12'd12));
        prog.push_back(lw(5'd8, 5'd1, 12'd12));
        runProgram("loadStore");
        for (int i = 0; i < 256; i++) begin
            checkWord($sformatf("loadStore word %0d", i), modelMem[i], dmem[i]);
        end
    endtask

    task automatic branches();
        prog.delete();
        prog.push_back(addi(5'd1, 5'd0, 12'd9));
        prog.push_back(addi(5'd2, 5'd0, 12'd9));
        prog.push_back(addi(5'd3, 5'd0, 12'd4));
        prog.push_back(beq(5'd1, 5'd2, 13'd12));
        prog.push_back(addi(5'd4, 5'd0, 12'd111));
        prog.push_back(addi(5'd5, 5'd0, 12'd222));
        prog.push_back(addi(5'd6, 5'd0, 12'd333));
        prog.push_back(beq(5'd1, 5'd3, 13'd8));
        prog.push_back(addi(5'd7, 5'd0, 12'd444));
        prog.push_back(rOp(7'h00, 3'd0, 5'd8, 5'd6, 5'd7));
        // Taken only after the interlock on x8
        prog.push_back(beq(5'd8, 5'd8, 13'd8));
        prog.push_back(addi(5'd9, 5'd0, 12'd555));
        prog.push_back(addi(5'd10, 5'd0, 12'd666));
        runProgram("branches");
    endtask

    task automatic presentInstr();
        if (fetchPc[1:0] == 2'b00 && (fetchPc >> 2) < prog.size()) begin
            instr      = prog[fetchPc >> 2];
            instrValid = 1'b1;
        end else begin
            instr      = '0;
            instrValid = 1'b0;
        end
    endtask

    // Program driver acting on values sampled mid-cycle
    always begin
        @(negedge clk);
        drvHold   = stallF;
        drvJump   = redirect;
        drvTarget = redirectPc;
        drvReset  = !arstN;
        @(posedge clk);
        #1;
        if (drvReset) begin
            fetchPc = '0;
        end else if (drvJump) begin
            fetchPc = drvTarget;
        end else if (!drvHold) begin
            fetchPc = fetchPc + 4;
        end
        presentInstr();
    end

    // Data memory with one LFSR step per ready bit
    always begin
        @(posedge clk);
        #1;
        lfsr     = lfsrStep(lfsr);
        memReady = lfsr[0];
        memRdata = dmem[memAddr[9:2]];
    end

    always @(negedge clk) begin
        if (arstN && memReq && memWe && memReady) begin
            dmem[memAddr[9:2]] = memWdata;
        end
    end

    // Retire monitor
    always @(negedge clk) begin
        if (!arstN) begin
            prevWait    = 1'b0;
            firstAccept = -1;
        end else if (prevWait && wbValid) begin
            failNow("an instruction retired right after a memory wait cycle");
        end else begin
            if (wbValid) begin
                retired.push_back('{valid: wbValid, rd: wbRd, data: wbData});
                retireCycle.push_back(cycle);
            end
            if (stallF) begin
                sawStall = 1'b1;
            end
            if (firstAccept < 0 && instrValid && !stallF) begin
                firstAccept = cycle;
            end
            prevWait = memReq && !memReady;
        end
    end

    initial begin
        #(WatchdogCycles * ClkPeriod);
        $display("Error: watchdog expired after %0d cycles", WatchdogCycles);
        $display("test failed");
        $fatal(1, "timeout");
    end

    initial begin
        arstN      = 1'b0;
        instr      = '0;
        fetchPc    = '0;
        instrValid = 1'b0;
        memRdata   = '0;
        memReady   = 1'b0;
        resetState();
        aluSequence();
        rawChains();
        loadStore();
        branches();
        $display("test passed");
        $finish;
    end

endmodule
